/* frontend.f */
+incdir+common
common/frontend_pkg.sv
bpu/ftb.sv
bpu/bpu.sv
hdl/ftq.sv
hdl/fetch_issue.sv
hdl/frontend_top.sv
tb/tb_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f frontend.f \
    && ./obj_dir/Vtb_frontend | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb/tb_frontend.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module tb_frontend;

    // test lengths in accepted fetch requests
    localparam int N_SEQ = 24;
    localparam int N_BR  = 12;
    localparam int N_RND = 60;
    // generous per-request budget for random stalls, plus reset and update time
    localparam int MAX_CYCLES = (N_SEQ + 3 * N_BR + N_RND) * 16 + 200;

    localparam logic [`XLEN-1:0] P_ADDR   = 32'h9000_0040;
    localparam logic [`XLEN-1:0] T_ADDR   = 32'ha000_0100;
    localparam logic [`XLEN-1:0] SQ_ADDR1 = 32'h8000_1000;
    localparam logic [`XLEN-1:0] SQ_ADDR2 = 32'h8000_2000;

    logic                          clk;
    logic                          rst;
    logic                          i_squash_vld;
    frontend_pkg::squash_info_t    i_squash_info;
    logic                          i_update_vld;
    logic                          o_update_finished;
    frontend_pkg::bp_update_info_t i_update_info;
    logic                          o_fetch_vld;
    frontend_pkg::fetch_req_t      o_fetch_req;
    logic                          i_fetch_rdy;

    // reference copy of the ftb contents
    logic                  m_valid  [`FTB_DEPTH];
    logic [`FTB_TAG_W-1:0] m_tag    [`FTB_DEPTH];
    logic [1:0]            m_slot   [`FTB_DEPTH];
    logic [1:0]            m_ctr    [`FTB_DEPTH];
    logic [`XLEN-1:0]      m_target [`FTB_DEPTH];

    frontend_pkg::fetch_req_t exp_q [$];
    frontend_pkg::fetch_req_t exp_head;
    logic [`XLEN-1:0]         gen_addr;
    logic [`FTQ_IDX_W-1:0]    gen_idx;

    int   fire_cnt = 0;
    int   fin_cnt = 0;
    int   cycle_cnt = 0;
    int   err_cnt = 0;
    int   upd_sent = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic rnd_stall;

    frontend_top i_frontend_top (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .i_squash_info     (i_squash_info),
        .i_update_vld      (i_update_vld),
        .o_update_finished (o_update_finished),
        .i_update_info     (i_update_info),
        .o_fetch_vld       (o_fetch_vld),
        .o_fetch_req       (o_fetch_req),
        .i_fetch_rdy       (i_fetch_rdy)
    );

    always #50 clk = ~clk;

    // next expected block from the block rules and the reference ftb
    task automatic push_expected();
        frontend_pkg::fetch_req_t r;
        logic [`FTB_IDX_W-1:0]    set;
        logic                     taken;
        set   = gen_addr[`FTB_OFS_W +: `FTB_IDX_W];
        taken = m_valid[set] && (m_tag[set] == gen_addr[`XLEN-1:`FTB_OFS_W+`FTB_IDX_W])
            && (m_ctr[set] >= 2'd2);
        r.addr     = gen_addr;
        r.byte_cnt = taken ? ({3'd0, m_slot[set]} + 5'd1) << 2 : 5'd16;
        r.ftq_idx  = gen_idx;
        exp_q.push_back(r);
        gen_addr = taken ? m_target[set] : gen_addr + 32'd16;
        gen_idx  = gen_idx + 1'b1;
    endtask

    task automatic restart_model(input logic [`XLEN-1:0] addr);
        exp_q.delete();
        gen_addr = addr;
        gen_idx  = '0;
        repeat (4) push_expected();
    endtask

    always @(posedge clk) begin
        if (rst) begin
            restart_model(`INIT_PC);
        end else begin
            if (o_update_finished) begin
                fin_cnt++;
            end
            if (i_squash_vld) begin
                restart_model(i_squash_info.arch_pc);
            end else if (o_fetch_vld && i_fetch_rdy) begin
                void'(exp_q.pop_front());
                push_expected();
                fire_cnt++;
            end
        end
        exp_head <= exp_q[0];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    a_fetch_order: assert property (@(posedge clk) disable iff (rst)
        o_fetch_vld && i_fetch_rdy |-> o_fetch_req == exp_head)
    else begin
        $display("[FAIL] %0t: got addr %h len %0d idx %0d, expected addr %h len %0d idx %0d",
            $time, $sampled(o_fetch_req.addr), $sampled(o_fetch_req.byte_cnt),
            $sampled(o_fetch_req.ftq_idx), $sampled(exp_head.addr),
            $sampled(exp_head.byte_cnt), $sampled(exp_head.ftq_idx));
        err_cnt++;
    end

    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        o_fetch_vld && !i_fetch_rdy && !i_squash_vld |=> o_fetch_vld && $stable(o_fetch_req))
    else begin
        $display("[FAIL] %0t: fetch request changed while stalled", $time);
        err_cnt++;
    end

    a_finish_pulse: assert property (@(posedge clk) disable iff (rst)
        o_update_finished |=> !o_update_finished)
    else begin
        $display("[FAIL] %0t: update finished high for more than one cycle", $time);
        err_cnt++;
    end

    task automatic next_cycle();
        @(negedge clk);
        if (rnd_stall) begin
            i_fetch_rdy = ($urandom % 4) != 0;
        end else begin
            i_fetch_rdy = 1'b1;
        end
    endtask

    task automatic wait_fetches(input int n);
        int target;
        target = fire_cnt + n;
        while (fire_cnt < target) begin
            next_cycle();
        end
    endtask

    task automatic send_update(input logic [`XLEN-1:0] pc, input logic [1:0] slot,
                               input logic [1:0] ctr, input logic [`XLEN-1:0] tgt);
        logic [`FTB_IDX_W-1:0] set;
        int                    waited;
        set = pc[`FTB_OFS_W +: `FTB_IDX_W];
        next_cycle();
        i_update_vld                         = 1'b1;
        i_update_info.start_addr             = pc;
        i_update_info.ftb_update.valid       = 1'b1;
        i_update_info.ftb_update.tag         = pc[`XLEN-1:`FTB_OFS_W+`FTB_IDX_W];
        i_update_info.ftb_update.br_offset   = slot;
        i_update_info.ftb_update.branch_type = frontend_pkg::BR_JAL;
        i_update_info.ftb_update.counter     = ctr;
        i_update_info.ftb_update.target      = tgt;
        m_valid[set]  = 1'b1;
        m_tag[set]    = pc[`XLEN-1:`FTB_OFS_W+`FTB_IDX_W];
        m_slot[set]   = slot;
        m_ctr[set]    = ctr;
        m_target[set] = tgt;
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (!o_update_finished && waited < 10);
        if (!o_update_finished) begin
            $display("update at %h was never acknowledged", pc);
            err_cnt++;
        end
        // hold through the edge that sees the acknowledge
        next_cycle();
        i_update_vld = 1'b0;
        upd_sent++;
    endtask

    task automatic send_squash(input logic [`XLEN-1:0] addr);
        next_cycle();
        i_fetch_rdy           = 1'b0;
        i_squash_vld          = 1'b1;
        i_squash_info.arch_pc = addr;
        next_cycle();
        i_squash_vld = 1'b0;
    endtask

    task automatic check_updates();
        if (fin_cnt != upd_sent) begin
            $display("[FAIL] %0t: %0d update acknowledges for %0d updates",
                $time, fin_cnt, upd_sent);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int lat;
        int errs;
        void'($urandom(32'h5886fb84));
        clk           = 1'b0;
        rst           = 1'b1;
        i_squash_vld  = 1'b0;
        i_squash_info = '0;
        i_update_vld  = 1'b0;
        i_update_info = '0;
        i_fetch_rdy   = 1'b1;
        rnd_stall     = 1'b0;
        for (int i = 0; i < `FTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // empty ftb, plain sequential blocks
        errs = err_cnt;
        lat  = 0;
        do begin
            next_cycle();
            lat++;
        end while (!o_fetch_vld && lat < 20);
        if (lat != 4) begin
            $display("[FAIL] %0t: first request %0d cycles after reset, expected 4", $time, lat);
            err_cnt++;
        end
        wait_fetches(N_SEQ);
        report_test("sequential after reset", errs);

        errs = err_cnt;
        send_update(P_ADDR, 2'd1, 2'd3, T_ADDR);
        send_squash(P_ADDR - 32'd32);
        wait_fetches(N_BR);
        check_updates();
        report_test("taken ftb entry", errs);

        // weak counter, same slot
        errs = err_cnt;
        send_update(P_ADDR, 2'd1, 2'd1, T_ADDR);
        send_squash(P_ADDR);
        wait_fetches(N_BR);
        check_updates();
        report_test("not taken ftb entry", errs);

        // second squash lands while the first is still in flight
        errs = err_cnt;
        send_squash(SQ_ADDR1);
        next_cycle();
        next_cycle();
        send_squash(SQ_ADDR2);
        wait_fetches(N_BR);
        report_test("squash redirect", errs);

        errs = err_cnt;
        rnd_stall = 1'b1;
        send_update(P_ADDR, 2'd1, 2'd2, T_ADDR);
        send_squash(P_ADDR - 32'd16);
        wait_fetches(N_RND);
        rnd_stall = 1'b0;
        check_updates();
        report_test("random back-pressure", errs);

        repeat (4) next_cycle();
        $display("summary: %0d tests, %0d failed, %0d check errors",
            tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* hdl/frontend_top.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module frontend_top (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          i_squash_vld,
    input  frontend_pkg::squash_info_t    i_squash_info,

    input  logic                          i_update_vld,
    output logic                          o_update_finished,
    input  frontend_pkg::bp_update_info_t i_update_info,

    output logic                          o_fetch_vld,
    output frontend_pkg::fetch_req_t      o_fetch_req,
    input  logic                          i_fetch_rdy
);

    logic                    pred_vld;
    logic                    ftq_rdy;
    frontend_pkg::ftq_info_t pred_info;

    logic                    deq_vld;
    logic                    deq_rdy;
    frontend_pkg::ftq_info_t deq_info;
    logic [`FTQ_IDX_W-1:0]   deq_idx;

    bpu u_bpu (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .i_squash_info     (i_squash_info),
        .i_update_vld      (i_update_vld),
        .o_update_finished (o_update_finished),
        .i_update_info     (i_update_info),
        .i_ftq_rdy         (ftq_rdy),
        .o_pred_vld        (pred_vld),
        .o_pred_ftq_info   (pred_info)
    );

    // a backend squash empties everything behind the bpu
    ftq u_ftq (
        .clk        (clk),
        .rst        (rst),
        .i_enq_vld  (pred_vld),
        .o_enq_rdy  (ftq_rdy),
        .i_enq_info (pred_info),
        .o_deq_vld  (deq_vld),
        .o_deq_info (deq_info),
        .o_deq_idx  (deq_idx),
        .i_deq_rdy  (deq_rdy),
        .i_flush    (i_squash_vld)
    );

    fetch_issue u_fetch_issue (
        .clk         (clk),
        .rst         (rst),
        .i_deq_vld   (deq_vld),
        .o_deq_rdy   (deq_rdy),
        .i_deq_info  (deq_info),
        .i_deq_idx   (deq_idx),
        .i_flush     (i_squash_vld),
        .o_fetch_vld (o_fetch_vld),
        .o_fetch_req (o_fetch_req),
        .i_fetch_rdy (i_fetch_rdy)
    );

endmodule

/* hdl/fetch_issue.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module fetch_issue (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     i_deq_vld,
    output logic                     o_deq_rdy,
    input  frontend_pkg::ftq_info_t  i_deq_info,
    input  logic [`FTQ_IDX_W-1:0]    i_deq_idx,

    input  logic                     i_flush,

    output logic                     o_fetch_vld,
    output frontend_pkg::fetch_req_t o_fetch_req,
    input  logic                     i_fetch_rdy
);

    logic                     req_vld;
    frontend_pkg::fetch_req_t req_q;
    logic                     pop;
    logic [`XLEN-1:0]         blk_bytes;

    // take a new block when empty or when the held one goes out
    assign o_deq_rdy = !req_vld || i_fetch_rdy;
    assign pop       = i_deq_vld && o_deq_rdy;

    // end_addr is inclusive
    assign blk_bytes = i_deq_info.end_addr - i_deq_info.start_addr + `XLEN'd1;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            req_vld <= 1'b0;
        end else if (pop) begin
            req_vld <= 1'b1;
        end else if (i_fetch_rdy) begin
            req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q.addr     <= i_deq_info.start_addr;
            req_q.byte_cnt <= blk_bytes[`FETCH_LEN_W-1:0];
            req_q.ftq_idx  <= i_deq_idx;
        end
    end

    assign o_fetch_vld = req_vld;
    assign o_fetch_req = req_q;

endmodule

/* hdl/ftq.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module ftq (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        i_enq_vld,
    output logic                        o_enq_rdy,
    input  frontend_pkg::ftq_info_t     i_enq_info,

    output logic                        o_deq_vld,
    output frontend_pkg::ftq_info_t     o_deq_info,
    output logic [`FTQ_IDX_W-1:0]       o_deq_idx,
    input  logic                        i_deq_rdy,

    input  logic                        i_flush
);

    frontend_pkg::ftq_info_t mem [`FTQ_DEPTH];

    logic [`FTQ_IDX_W-1:0] wr_ptr;
    logic [`FTQ_IDX_W-1:0] rd_ptr;
    logic [`FTQ_IDX_W:0]   count;
    logic                  enq_fire;
    logic                  deq_fire;

    assign o_enq_rdy = (count != `FTQ_DEPTH);
    assign o_deq_vld = (count != '0);
    assign enq_fire  = i_enq_vld && o_enq_rdy;
    assign deq_fire  = o_deq_vld && i_deq_rdy;

    assign o_deq_info = mem[rd_ptr];
    // the slot number doubles as the ftq index
    assign o_deq_idx  = rd_ptr;

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= i_enq_info;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_fire, deq_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a full queue has its write pointer wrapped back onto the read pointer
    a_full_ptrs: assert property (@(posedge clk) disable iff (rst)
        !o_enq_rdy |-> wr_ptr == rd_ptr);

    // an empty queue has both pointers on the same slot
    a_empty_ptrs: assert property (@(posedge clk) disable iff (rst)
        !o_deq_vld |-> wr_ptr == rd_ptr);

endmodule

/* bpu/bpu.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module bpu (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          i_squash_vld,
    input  frontend_pkg::squash_info_t    i_squash_info,

    input  logic                          i_update_vld,
    output logic                          o_update_finished,
    input  frontend_pkg::bp_update_info_t i_update_info,

    // prediction out to the ftq
    input  logic                          i_ftq_rdy,
    output logic                          o_pred_vld,
    output frontend_pkg::ftq_info_t       o_pred_ftq_info
);

    logic [`XLEN-1:0]        base_pc;
    logic [`XLEN-1:0]        s1_base_pc;
    logic [`XLEN-1:0]        s2_base_pc;

    logic                    lookup_req;
    logic                    advance;
    logic                    s1_vld;
    logic                    s1_hit;
    logic                    s2_vld;
    logic                    s2_hit;
    frontend_pkg::ftb_info_t s2_info;

    logic                    s2_taken;
    logic                    s2_pred_use;
    logic                    pred_fire;
    logic                    redirect;
    logic                    kill;
    logic [`XLEN-1:0]        s2_npc;

    // s2 is free or leaves this cycle
    assign lookup_req = !s2_vld || i_ftq_rdy;

    ftb u_ftb (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (kill),
        .i_lookup_req      (lookup_req),
        .o_lookup_gnt      (advance),
        .i_lookup_pc       (base_pc),
        .o_lookup_info     (s2_info),
        .o_lookup_hit      (s1_hit),
        .o_lookup_hit_rdy  (s1_vld),
        .i_update_req      (i_update_vld),
        .o_update_finished (o_update_finished),
        .i_update_pc       (i_update_info.start_addr),
        .i_update_info     (i_update_info.ftb_update)
    );

    assign s2_taken    = s2_info.counter >= 2'd2;
    assign s2_pred_use = s2_vld && s2_hit && s2_taken;
    assign s2_npc      = frontend_pkg::calc_npc(s2_base_pc, s2_pred_use, s2_info);

    assign o_pred_vld = s2_vld && !i_update_vld;
    assign pred_fire  = o_pred_vld && i_ftq_rdy;

    // a taken block redirects only once the ftq has it
    assign redirect = s2_pred_use && pred_fire;
    assign kill     = i_squash_vld || i_update_vld || redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld <= 1'b0;
        end else if (kill) begin
            s2_vld <= 1'b0;
        end else if (advance) begin
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_base_pc <= base_pc;
            s2_base_pc <= s1_base_pc;
            s2_hit     <= s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= `INIT_PC;
        end else if (i_squash_vld) begin
            base_pc <= i_squash_info.arch_pc;
        end else if (i_update_vld) begin
            // restart from the oldest block the ftq has not taken yet
            base_pc <= s2_vld ? s2_base_pc : (s1_vld ? s1_base_pc : base_pc);
        end else if (redirect) begin
            base_pc <= s2_npc;
        end else if (advance) begin
            base_pc <= base_pc + `XLEN'(`FTB_PREDICT_WIDTH);
        end
    end

    always_comb begin
        o_pred_ftq_info.start_addr  = s2_base_pc;
        o_pred_ftq_info.end_addr    = s2_pred_use ?
            frontend_pkg::calc_fallthru_addr(s2_base_pc, s2_info) - `XLEN'd1 :
            s2_base_pc + `XLEN'(`FTB_PREDICT_WIDTH - 1);
        o_pred_ftq_info.taken       = s2_hit && s2_taken;
        o_pred_ftq_info.target_addr = frontend_pkg::calc_target_addr(s2_info);
        o_pred_ftq_info.hit_on_ftb  = s2_hit;
        o_pred_ftq_info.branch_type = s2_info.branch_type;
        // weakly not taken on a miss
        o_pred_ftq_info.ftb_counter = s2_hit ? s2_info.counter : 2'd1;
    end

    // an offer waits unchanged for the ftq until a squash or an update withdraws it
    a_pred_hold: assert property (@(posedge clk) disable iff (rst)
        o_pred_vld && !i_ftq_rdy && !i_squash_vld |=>
            (o_pred_vld || i_update_vld) && $stable(o_pred_ftq_info));

endmodule

/* bpu/ftb.sv */
`timescale 1ns/100ps
`include "frontend_defs.svh"

module ftb (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_squash_vld,

    // lookup, hit one cycle later, entry two cycles later
    input  logic                    i_lookup_req,
    output logic                    o_lookup_gnt,
    input  logic [`XLEN-1:0]        i_lookup_pc,
    output frontend_pkg::ftb_info_t o_lookup_info,
    output logic                    o_lookup_hit,
    output logic                    o_lookup_hit_rdy,

    // update from the backend
    input  logic                    i_update_req,
    output logic                    o_update_finished,
    input  logic [`XLEN-1:0]        i_update_pc,
    input  frontend_pkg::ftb_info_t i_update_info
);

    frontend_pkg::ftb_info_t entries [`FTB_DEPTH];

    logic [`FTB_IDX_W-1:0]   s1_idx;
    logic [`FTB_TAG_W-1:0]   s1_tag;
    logic                    s1_vld;
    frontend_pkg::ftb_info_t s1_entry;
    frontend_pkg::ftb_info_t s2_entry;

    logic                    upd_we;
    logic                    upd_done;
    logic [`FTB_IDX_W-1:0]   upd_idx;
    frontend_pkg::ftb_info_t upd_entry;

    // lookups wait while the array is being written
    assign o_lookup_gnt = i_lookup_req && !i_update_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (i_squash_vld) begin
            s1_vld <= 1'b0;
        end else if (o_lookup_gnt) begin
            s1_vld <= 1'b1;
        end
    end

    // s1 index and tag, s2 entry, both move only on a granted lookup
    always_ff @(posedge clk) begin
        if (o_lookup_gnt) begin
            s1_idx   <= i_lookup_pc[`FTB_OFS_W +: `FTB_IDX_W];
            s1_tag   <= i_lookup_pc[`XLEN-1 : `FTB_OFS_W+`FTB_IDX_W];
            s2_entry <= s1_entry;
        end
    end

    assign s1_entry         = entries[s1_idx];
    assign o_lookup_hit     = s1_entry.valid && (s1_entry.tag == s1_tag);
    assign o_lookup_hit_rdy = s1_vld;
    assign o_lookup_info    = s2_entry;

    // one write per request, finished pulses the cycle after
    assign upd_we  = i_update_req && !upd_done;
    assign upd_idx = i_update_pc[`FTB_OFS_W +: `FTB_IDX_W];

    always_comb begin
        upd_entry     = i_update_info;
        upd_entry.tag = i_update_pc[`XLEN-1 : `FTB_OFS_W+`FTB_IDX_W];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FTB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd_we) begin
            entries[upd_idx] <= upd_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_done <= 1'b0;
        end else begin
            upd_done <= upd_we;
        end
    end

    assign o_update_finished = upd_done;

    // backend keeps the same update until it is acknowledged
    a_update_held: assert property (@(posedge clk) disable iff (rst)
        i_update_req && !o_update_finished |=> i_update_req && $stable(i_update_pc));

endmodule

/* common/frontend_pkg.sv */
`include "frontend_defs.svh"

package frontend_pkg;

    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JAL  = 2'd1,
        BR_JALR = 2'd2,
        BR_CALL = 2'd3
    } branch_type_e;

    // one ftb entry
    typedef struct packed {
        logic                  valid;
        logic [`FTB_TAG_W-1:0] tag;
        // instruction slot of the branch inside the block
        logic [1:0]            br_offset;
        branch_type_e          branch_type;
        logic [1:0]            counter;
        logic [`XLEN-1:0]      target;
    } ftb_info_t;

    typedef struct packed {
        logic [`XLEN-1:0] arch_pc;
    } squash_info_t;

    typedef struct packed {
        logic [`XLEN-1:0] start_addr;
        ftb_info_t        ftb_update;
    } bp_update_info_t;

    // one predicted fetch block
    typedef struct packed {
        logic [`XLEN-1:0] start_addr;
        // last byte of the block, inclusive
        logic [`XLEN-1:0] end_addr;
        logic             taken;
        logic [`XLEN-1:0] target_addr;
        logic             hit_on_ftb;
        branch_type_e     branch_type;
        logic [1:0]       ftb_counter;
    } ftq_info_t;

    typedef struct packed {
        logic [`XLEN-1:0]        addr;
        logic [`FETCH_LEN_W-1:0] byte_cnt;
        logic [`FTQ_IDX_W-1:0]   ftq_idx;
    } fetch_req_t;

    // first byte after the recorded branch
    function automatic logic [`XLEN-1:0] calc_fallthru_addr(
        input logic [`XLEN-1:0] base,
        input ftb_info_t        info
    );
        return base + ((`XLEN'(info.br_offset) + `XLEN'd1) << 2);
    endfunction

    function automatic logic [`XLEN-1:0] calc_target_addr(input ftb_info_t info);
        return info.target;
    endfunction

    function automatic logic [`XLEN-1:0] calc_npc(
        input logic [`XLEN-1:0] base,
        input logic             taken,
        input ftb_info_t        info
    );
        return taken ? calc_target_addr(info) : calc_fallthru_addr(base, info);
    endfunction

endpackage

/* common/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// address and data path width
`define XLEN 32

// one fetch block covers four 4-byte instructions
`define FTB_PREDICT_WIDTH 16

// fetch address after reset
`define INIT_PC 32'h8000_0000

// byte offset bits inside a fetch block
`define FTB_OFS_W 4

// direct-mapped ftb, indexed by pc[7:4]
`define FTB_DEPTH 16
`define FTB_IDX_W 4

// tag is whatever is left above the index
`define FTB_TAG_W (`XLEN - `FTB_OFS_W - `FTB_IDX_W)

// fetch target queue
`define FTQ_DEPTH 8
`define FTQ_IDX_W 3

// byte count of a fetch request, up to 16
`define FETCH_LEN_W 5

`endif
